// File: pipe_hazard_unit.f
+incdir+src
+incdir+sim
src/rv_ops_pkg.sv
src/pipe_info_pkg.sv
src/operand_hazard_check.sv
src/flush_detect.sv
src/stage_ctrl_merge.sv
src/pipe_hazard_unit.sv
sim/tb_pipe_hazard_unit.sv

// File: Bender.yml
package:
  name: pipe_hazard_unit

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/rv_ops_pkg.sv
      - src/pipe_info_pkg.sv
      - src/operand_hazard_check.sv
      - src/flush_detect.sv
      - src/stage_ctrl_merge.sv
      - src/pipe_hazard_unit.sv
  - target: simulation
    include_dirs:
      - src
      - sim
    files:
      - sim/tb_pipe_hazard_unit.sv

// File: sim/hazard_ref_model.svh
`ifndef HAZARD_REF_MODEL_SVH
`define HAZARD_REF_MODEL_SVH

// Expected stage controls for one set of pipeline summaries.
function automatic stage_ctrl_t model_stage_ctrl(
    input id_info_t     id,
    input exe_info_t    ex,
    input mem_info_t    mm,
    input wb_info_t     wb,
    input ifreg_sel_e   isel,
    input wb_redirect_e wred,
    input logic         if_rdy,
    input logic         mem_rdy
);
    logic ex_wr, mm_wr, wb_wr, mm_cwr, wb_cwr;
    logic id_r1, id_r2, ex_r1, ex_r2, ex_rc, mm_r2;
    logic id_c, ex_c, mm_c;
    logic t_id, t_ex, t_mm, t_wb;
    logic redir, fence, fwait;
    stage_ctrl_t c;

    ex_wr  = ex.valid && ex.wb_sel != WB_NONE;
    mm_wr  = mm.valid && mm.wb_sel != WB_NONE;
    wb_wr  = wb.valid && wb.wb_sel != WB_NONE;
    mm_cwr = mm.valid && (mm.wb_sel == WB_CSRRW || mm.wb_sel == WB_CSRRS ||
                          mm.wb_sel == WB_CSRRWI);
    wb_cwr = wb.valid && (wb.wb_sel == WB_CSRRW || wb.wb_sel == WB_CSRRS ||
                          wb.wb_sel == WB_CSRRWI);

    id_r1 = id.valid && (id.ctrl == CD_BRANCH || id.ctrl == CD_JALR);
    id_r2 = id.valid && id.ctrl == CD_BRANCH;
    ex_r1 = 1'b0;
    ex_r2 = 1'b0;
    ex_rc = 1'b0;
    if (ex.valid && ex.op != EXE_NOP) begin
        ex_r1 = ex.src == SRC_R_R || ex.src == SRC_R_I || ex.src == SRC_R_CSR ||
                ex.src == SRC_NOTR_CSR;
        ex_r2 = ex.src == SRC_R_R;
        ex_rc = ex.src == SRC_R_CSR || ex.src == SRC_NOTR_CSR ||
                ex.src == SRC_CSR_ZIMM || ex.src == SRC_CSR_NOTZIMM;
    end
    mm_r2 = mm.valid && (mm.op == MEM_SB || mm.op == MEM_SH || mm.op == MEM_SW ||
                         mm.op == MEM_SD);

    id_c = (id_r1 && ((ex_wr && id.rs1 == ex.rd) || (mm_wr && id.rs1 == mm.rd) ||
                      (wb_wr && id.rs1 == wb.rd))) ||
           (id_r2 && ((ex_wr && id.rs2 == ex.rd) || (mm_wr && id.rs2 == mm.rd) ||
                      (wb_wr && id.rs2 == wb.rd)));
    ex_c = (ex_r1 && ((mm_wr && ex.rs1 == mm.rd) || (wb_wr && ex.rs1 == wb.rd))) ||
           (ex_r2 && ((mm_wr && ex.rs2 == mm.rd) || (wb_wr && ex.rs2 == wb.rd))) ||
           (ex_rc && ((mm_cwr && ex.csr == mm.csr) || (wb_cwr && ex.csr == wb.csr)));
    mm_c = mm_r2 && wb_wr && mm.rs2 == wb.rd;

    t_wb  = wb.valid && wb.trap != TRAP_NOP;
    t_mm  = t_wb || (mm.valid && mm.trap != TRAP_NOP);
    t_ex  = t_mm || (ex.valid && ex.trap != TRAP_NOP);
    t_id  = t_ex || (id.valid && id.trap != TRAP_NOP);
    redir = isel == IFREG_ID_PC || wred != WBR_NONE;
    fence = id.valid && id.ctrl == CD_FENCE_I;
    fwait = fence && (ex.valid || mm.valid);

    c.if_enable  = !fwait && mem_rdy && if_rdy && !(id_c || ex_c || mm_c);
    c.if_valid   = !(fwait || redir || t_id || id_c);
    c.id_enable  = !fwait && mem_rdy && !(id_c || ex_c || mm_c);
    c.id_valid   = !(redir || t_id || fence);
    c.exe_enable = mem_rdy && !ex_c && !mm_c;
    c.exe_valid  = !(fence || t_ex || id_c);
    c.mem_enable = mem_rdy && !mm_c;
    c.mem_valid  = !(t_mm || ex_c);
    c.wb_valid   = !(mm_c || t_wb);
    return c;
endfunction

`endif

// File: sim/tb_pipe_hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_hazard_unit;

    import rv_ops_pkg::*;
    import pipe_info_pkg::*;

    `include "hazard_defines.svh"
    `include "hazard_ref_model.svh"

    localparam int CLK_NS = 100;
    localparam int M_QUIET = 1;
    localparam int M_HAZARD = 2;
    localparam int M_TRAP = 3;
    localparam int M_FENCE = 4;
    localparam int M_BACK = 5;
    localparam int M_MIX = 6;
    localparam int TOTAL_CYCLES = 40 + 200 + 200 + 100 + 100 + 600;
    localparam int WATCHDOG_NS = (TOTAL_CYCLES + 5 + 50) * CLK_NS;

    logic clk;
    logic reset;
    id_info_t id_info;
    exe_info_t exe_info;
    mem_info_t mem_info;
    wb_info_t wb_info;
    ifreg_sel_e ifreg_sel;
    wb_redirect_e wb_redirect;
    logic if_ok;
    logic mem_ok;
    stage_ctrl_t stage_ctrl;

    integer seed = 32'h4ad1c108;
    int checks = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    logic [`REG_ADDR_W-1:0] reg_pool [4] = '{5'd1, 5'd2, 5'd7, 5'd31};  // Small pool makes matches common.
    logic [`CSR_ADDR_W-1:0] csr_pool [4] = '{12'h300, 12'h305, 12'h341, 12'h342};

    pipe_hazard_unit dut0 (
        .id_info     (id_info),
        .exe_info    (exe_info),
        .mem_info    (mem_info),
        .wb_info     (wb_info),
        .ifreg_sel   (ifreg_sel),
        .wb_redirect (wb_redirect),
        .if_ok       (if_ok),
        .mem_ok      (mem_ok),
        .stage_ctrl  (stage_ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic trap_e draw_trap();
        return (pick(4) == 0) ? trap_e'(1 + pick(8)) : TRAP_NOP;
    endfunction

    // New random inputs shaped by the test mode.
    task automatic drive_random(input int mode);
        id_info_t id;
        exe_info_t ex;
        mem_info_t mm;
        wb_info_t wb;
        ifreg_sel_e isel;
        wb_redirect_e wred;
        logic ifr;
        logic memr;
        id = '{pick(4) != 0, cd_ctrl_e'(pick(7)), reg_pool[pick(4)], reg_pool[pick(4)],
               draw_trap()};
        ex = '{pick(4) != 0, exe_op_e'(pick(14)), exe_src_e'(pick(8)), wb_sel_e'(pick(8)),
               reg_pool[pick(4)], reg_pool[pick(4)], reg_pool[pick(4)], csr_pool[pick(4)],
               draw_trap()};
        mm = '{pick(4) != 0, mem_op_e'(pick(12)), wb_sel_e'(pick(8)), reg_pool[pick(4)],
               reg_pool[pick(4)], csr_pool[pick(4)], draw_trap()};
        wb = '{pick(4) != 0, wb_sel_e'(pick(8)), reg_pool[pick(4)], csr_pool[pick(4)],
               draw_trap()};
        isel = (pick(4) == 0) ? IFREG_ID_PC : IFREG_SEQ;
        wred = (pick(6) == 0) ? wb_redirect_e'(1 + pick(2)) : WBR_NONE;
        ifr  = pick(5) != 0;
        memr = pick(5) != 0;
        if (mode != M_MIX && mode != M_TRAP) begin
            id.trap = TRAP_NOP;
            ex.trap = TRAP_NOP;
            mm.trap = TRAP_NOP;
            wb.trap = TRAP_NOP;
            isel = IFREG_SEQ;
            wred = WBR_NONE;
        end
        if (mode == M_QUIET || mode == M_TRAP || mode == M_FENCE || mode == M_BACK) begin
            ex.wb_sel = WB_NONE;  // Writers off so nothing conflicts.
            mm.wb_sel = WB_NONE;
            wb.wb_sel = WB_NONE;
        end
        if (mode == M_QUIET || mode == M_BACK)
            id.ctrl = CD_OTHER;
        else if (mode == M_FENCE)
            id = '{1'b1, CD_FENCE_I, id.rs1, id.rs2, TRAP_NOP};
        else if (mode != M_MIX && id.ctrl == CD_FENCE_I)
            id.ctrl = CD_BRANCH;
        if (mode != M_MIX && mode != M_BACK) begin
            ifr  = 1'b1;
            memr = 1'b1;
        end
        if (reset) begin
            id.valid = 1'b0;  // Stages empty during reset.
            ex.valid = 1'b0;
            mm.valid = 1'b0;
            wb.valid = 1'b0;
        end
        id_info     <= id;
        exe_info    <= ex;
        mem_info    <= mm;
        wb_info     <= wb;
        ifreg_sel   <= isel;
        wb_redirect <= wred;
        if_ok       <= ifr;
        mem_ok      <= memr;
    endtask

    task automatic compare_value(input string name, input logic [8:0] expected,
                                 input logic [8:0] actual, inout int errs);
        checks++;
        assert (actual === expected) else begin
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
            errs++;
        end
    endtask

    task automatic check_outputs(input string name, input int mode, inout int errs);
        stage_ctrl_t exp;
        logic [8:0] enables;
        exp = model_stage_ctrl(id_info, exe_info, mem_info, wb_info, ifreg_sel, wb_redirect,
                               if_ok, mem_ok);
        enables = {5'd0, stage_ctrl.if_enable, stage_ctrl.id_enable, stage_ctrl.exe_enable,
                   stage_ctrl.mem_enable};
        compare_value(name, exp, stage_ctrl, errs);
        if (mode == M_QUIET)
            compare_value(name, 9'h1ff, stage_ctrl, errs);
        else if (mode == M_TRAP)
            compare_value(name, 9'h00f, enables, errs);  // Flushes never stall.
        else if (mode == M_BACK)
            compare_value(name, !mem_ok ? 9'h000 : (!if_ok ? 9'h007 : 9'h00f), enables, errs);
    endtask

    task automatic run_test(input string name, input int mode, input int cycles);
        int errs;
        errs = 0;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            drive_random(mode);
            @(negedge clk);
            check_outputs(name, mode, errs);
        end
        if (errs == 0)
            tests_passed++;
        else
            tests_failed++;
        $display("test %-18s %4d cycles  %0d errors", name, cycles, errs);
    endtask

    initial begin
        id_info     = '0;
        exe_info    = '0;
        mem_info    = '0;
        wb_info     = '0;
        ifreg_sel   = IFREG_SEQ;
        wb_redirect = WBR_NONE;
        if_ok       = 1'b1;
        mem_ok      = 1'b1;
        reset       = 1'b1;
        repeat (5) begin
            @(posedge clk);
            drive_random(M_QUIET);
        end
        reset <= 1'b0;
        run_test("quiet_pipeline", M_QUIET, 40);
        run_test("operand_hazards", M_HAZARD, 200);
        run_test("traps_redirects", M_TRAP, 200);
        run_test("fence_i", M_FENCE, 100);
        run_test("back_pressure", M_BACK, 100);
        run_test("random_mix", M_MIX, 600);
        $display("Tests passed %0d, failed %0d, checks %0d", tests_passed, tests_failed, checks);
        if (tests_failed == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Run timed out after %0d ns before all tests finished", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/pipe_hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_hazard_unit (
    input  pipe_info_pkg::id_info_t     id_info,
    input  pipe_info_pkg::exe_info_t    exe_info,
    input  pipe_info_pkg::mem_info_t    mem_info,
    input  pipe_info_pkg::wb_info_t     wb_info,
    input  rv_ops_pkg::ifreg_sel_e      ifreg_sel,
    input  rv_ops_pkg::wb_redirect_e    wb_redirect,
    input  logic                        if_ok,
    input  logic                        mem_ok,
    output pipe_info_pkg::stage_ctrl_t  stage_ctrl
);

    import pipe_info_pkg::*;

    hazard_flags_t hazard_flags;
    flush_flags_t  flush_flags;

    operand_hazard_check u_operand_hazard_check (
        .id_info      (id_info),
        .exe_info     (exe_info),
        .mem_info     (mem_info),
        .wb_info      (wb_info),
        .hazard_flags (hazard_flags)
    );

    flush_detect u_flush_detect (
        .id_info      (id_info),
        .exe_valid    (exe_info.valid),
        .mem_valid_in (mem_info.valid),
        .exe_trap     (exe_info.trap),
        .mem_trap     (mem_info.trap),
        .wb_valid_in  (wb_info.valid),
        .wb_trap      (wb_info.trap),
        .ifreg_sel    (ifreg_sel),
        .wb_redirect  (wb_redirect),
        .flush_flags  (flush_flags)
    );

    stage_ctrl_merge u_stage_ctrl_merge (
        .hazard_flags (hazard_flags),
        .flush_flags  (flush_flags),
        .if_ok        (if_ok),
        .mem_ok       (mem_ok),
        .stage_ctrl   (stage_ctrl)
    );

endmodule

`default_nettype wire

// File: src/stage_ctrl_merge.sv
`timescale 1ns/1ps
`default_nettype none

module stage_ctrl_merge (
    input  pipe_info_pkg::hazard_flags_t hazard_flags,
    input  pipe_info_pkg::flush_flags_t  flush_flags,
    input  logic                         if_ok,
    input  logic                         mem_ok,
    output pipe_info_pkg::stage_ctrl_t   stage_ctrl
);

    logic any_conflict;
    logic late_conflict;
    logic front_squash;

    assign any_conflict  = hazard_flags.id_conflict || hazard_flags.exe_conflict ||
                           hazard_flags.mem_conflict;
    assign late_conflict = hazard_flags.exe_conflict || hazard_flags.mem_conflict;

    // Redirect or trap kills what IF and ID hold.
    assign front_squash  = flush_flags.redirect || flush_flags.trap_from_id;

    // Enables hold a stage and everything before it.
    always_comb begin
        stage_ctrl.if_enable  = !(flush_flags.fence_wait || !mem_ok || !if_ok ||
                                  any_conflict);
        stage_ctrl.id_enable  = !(flush_flags.fence_wait || !mem_ok || any_conflict);
        stage_ctrl.exe_enable = !(!mem_ok || late_conflict);
        stage_ctrl.mem_enable = !(!mem_ok || hazard_flags.mem_conflict);
    end

    // Valids bubble below a stall or squash.
    always_comb begin
        stage_ctrl.if_valid  = !(flush_flags.fence_wait || front_squash ||
                                 hazard_flags.id_conflict);
        stage_ctrl.id_valid  = !(front_squash || flush_flags.fence_in_id);
        stage_ctrl.exe_valid = !(flush_flags.fence_in_id || flush_flags.trap_from_exe ||
                                 hazard_flags.id_conflict);
        stage_ctrl.mem_valid = !(flush_flags.trap_from_mem || hazard_flags.exe_conflict);
        stage_ctrl.wb_valid  = !(hazard_flags.mem_conflict || flush_flags.trap_wb);
    end

endmodule

`default_nettype wire

// File: src/flush_detect.sv
`timescale 1ns/1ps
`default_nettype none

module flush_detect (
    input  pipe_info_pkg::id_info_t     id_info,
    input  logic                        exe_valid,
    input  logic                        mem_valid_in,
    input  rv_ops_pkg::trap_e           exe_trap,
    input  rv_ops_pkg::trap_e           mem_trap,
    input  logic                        wb_valid_in,
    input  rv_ops_pkg::trap_e           wb_trap,
    input  rv_ops_pkg::ifreg_sel_e      ifreg_sel,
    input  rv_ops_pkg::wb_redirect_e    wb_redirect,
    output pipe_info_pkg::flush_flags_t flush_flags
);

    import rv_ops_pkg::*;

    logic id_traps;
    logic exe_traps;
    logic mem_traps;
    logic wb_traps;
    logic fence_in_id;

    // A trap only counts for a live instruction.
    assign id_traps  = id_info.valid && (id_info.trap != TRAP_NOP);
    assign exe_traps = exe_valid && (exe_trap != TRAP_NOP);
    assign mem_traps = mem_valid_in && (mem_trap != TRAP_NOP);
    assign wb_traps  = wb_valid_in && (wb_trap != TRAP_NOP);

    assign fence_in_id = id_info.valid && (id_info.ctrl == CD_FENCE_I);

    always_comb begin
        flush_flags.redirect      = (ifreg_sel == IFREG_ID_PC) || (wb_redirect != WBR_NONE);
        flush_flags.fence_in_id   = fence_in_id;
        flush_flags.fence_wait    = fence_in_id && (exe_valid || mem_valid_in);  // Drain first.

        // Cumulative from the oldest stage upward.
        flush_flags.trap_wb       = wb_traps;
        flush_flags.trap_from_mem = mem_traps || wb_traps;
        flush_flags.trap_from_exe = exe_traps || mem_traps || wb_traps;
        flush_flags.trap_from_id  = id_traps || exe_traps || mem_traps || wb_traps;
    end

endmodule

`default_nettype wire

// File: src/operand_hazard_check.sv
`timescale 1ns/1ps
`default_nettype none

module operand_hazard_check (
    input  pipe_info_pkg::id_info_t      id_info,
    input  pipe_info_pkg::exe_info_t     exe_info,
    input  pipe_info_pkg::mem_info_t     mem_info,
    input  pipe_info_pkg::wb_info_t      wb_info,
    output pipe_info_pkg::hazard_flags_t hazard_flags
);

    import rv_ops_pkg::*;

    logic id_rs1_read;
    logic id_rs2_read;
    logic exe_rs1_read;
    logic exe_rs2_read;
    logic exe_csr_read;
    logic mem_rs2_read;

    logic exe_rd_write;
    logic mem_rd_write;
    logic wb_rd_write;
    logic mem_csr_write;
    logic wb_csr_write;

    // Any writeback source lands in rd.
    function automatic logic writes_rd(input logic valid, input wb_sel_e sel);
        return valid && (sel != WB_NONE);
    endfunction

    function automatic logic writes_csr(input logic valid, input wb_sel_e sel);
        return valid && (sel == WB_CSRRW || sel == WB_CSRRS || sel == WB_CSRRWI);
    endfunction

    assign exe_rd_write  = writes_rd(exe_info.valid, exe_info.wb_sel);
    assign mem_rd_write  = writes_rd(mem_info.valid, mem_info.wb_sel);
    assign wb_rd_write   = writes_rd(wb_info.valid, wb_info.wb_sel);
    assign mem_csr_write = writes_csr(mem_info.valid, mem_info.wb_sel);
    assign wb_csr_write  = writes_csr(wb_info.valid, wb_info.wb_sel);

    // Branch operands are compared in ID.
    assign id_rs1_read = id_info.valid && (id_info.ctrl == CD_BRANCH || id_info.ctrl == CD_JALR);
    assign id_rs2_read = id_info.valid && (id_info.ctrl == CD_BRANCH);

    always_comb begin
        exe_rs1_read = 1'b0;
        exe_rs2_read = 1'b0;
        exe_csr_read = 1'b0;
        if (exe_info.valid && exe_info.op != EXE_NOP) begin
            case (exe_info.src)
                SRC_R_R: begin
                    exe_rs1_read = 1'b1;
                    exe_rs2_read = 1'b1;
                end
                SRC_R_I: begin
                    exe_rs1_read = 1'b1;
                end
                SRC_R_CSR, SRC_NOTR_CSR: begin
                    exe_rs1_read = 1'b1;
                    exe_csr_read = 1'b1;
                end
                SRC_CSR_ZIMM, SRC_CSR_NOTZIMM: begin
                    exe_csr_read = 1'b1;   // Immediate replaces rs1.
                end
                default: begin
                    exe_rs1_read = 1'b0;
                end
            endcase
        end
    end

    // Store data comes from rs2.
    always_comb begin
        mem_rs2_read = 1'b0;
        if (mem_info.valid) begin
            case (mem_info.op)
                MEM_SB, MEM_SH, MEM_SW, MEM_SD: mem_rs2_read = 1'b1;
                default: mem_rs2_read = 1'b0;
            endcase
        end
    end

    // Younger reader against every older writer.
    always_comb begin
        hazard_flags.id_conflict =
            (id_rs1_read && exe_rd_write && id_info.rs1 == exe_info.rd) ||
            (id_rs1_read && mem_rd_write && id_info.rs1 == mem_info.rd) ||
            (id_rs1_read && wb_rd_write  && id_info.rs1 == wb_info.rd)  ||
            (id_rs2_read && exe_rd_write && id_info.rs2 == exe_info.rd) ||
            (id_rs2_read && mem_rd_write && id_info.rs2 == mem_info.rd) ||
            (id_rs2_read && wb_rd_write  && id_info.rs2 == wb_info.rd);

        hazard_flags.exe_conflict =
            (exe_rs1_read && mem_rd_write  && exe_info.rs1 == mem_info.rd)  ||
            (exe_rs1_read && wb_rd_write   && exe_info.rs1 == wb_info.rd)   ||
            (exe_rs2_read && mem_rd_write  && exe_info.rs2 == mem_info.rd)  ||
            (exe_rs2_read && wb_rd_write   && exe_info.rs2 == wb_info.rd)   ||
            (exe_csr_read && mem_csr_write && exe_info.csr == mem_info.csr) ||
            (exe_csr_read && wb_csr_write  && exe_info.csr == wb_info.csr);

        hazard_flags.mem_conflict =
            mem_rs2_read && wb_rd_write && mem_info.rs2 == wb_info.rd;
    end

endmodule

`default_nettype wire

// File: src/pipe_info_pkg.sv
`default_nettype none

`include "hazard_defines.svh"

package pipe_info_pkg;

    // Decode stage summary.
    typedef struct packed {
        logic                     valid;
        rv_ops_pkg::cd_ctrl_e     ctrl;
        logic [`REG_ADDR_W-1:0]   rs1;
        logic [`REG_ADDR_W-1:0]   rs2;
        rv_ops_pkg::trap_e        trap;
    } id_info_t;

    // Execute stage summary.
    typedef struct packed {
        logic                     valid;
        rv_ops_pkg::exe_op_e      op;
        rv_ops_pkg::exe_src_e     src;
        rv_ops_pkg::wb_sel_e      wb_sel;
        logic [`REG_ADDR_W-1:0]   rd;
        logic [`REG_ADDR_W-1:0]   rs1;
        logic [`REG_ADDR_W-1:0]   rs2;
        logic [`CSR_ADDR_W-1:0]   csr;
        rv_ops_pkg::trap_e        trap;
    } exe_info_t;

    // Memory stage summary.
    typedef struct packed {
        logic                     valid;
        rv_ops_pkg::mem_op_e      op;
        rv_ops_pkg::wb_sel_e      wb_sel;
        logic [`REG_ADDR_W-1:0]   rd;
        logic [`REG_ADDR_W-1:0]   rs2;
        logic [`CSR_ADDR_W-1:0]   csr;
        rv_ops_pkg::trap_e        trap;
    } mem_info_t;

    // Writeback stage summary.
    typedef struct packed {
        logic                     valid;
        rv_ops_pkg::wb_sel_e      wb_sel;
        logic [`REG_ADDR_W-1:0]   rd;
        logic [`CSR_ADDR_W-1:0]   csr;
        rv_ops_pkg::trap_e        trap;
    } wb_info_t;

    typedef struct packed {
        logic id_conflict;
        logic exe_conflict;
        logic mem_conflict;
    } hazard_flags_t;

    typedef struct packed {
        logic redirect;
        logic fence_in_id;
        logic fence_wait;         // Fence.i blocked by older work.
        logic trap_from_id;       // Trap in ID or later.
        logic trap_from_exe;      // Trap in EXE or later.
        logic trap_from_mem;      // Trap in MEM or WB.
        logic trap_wb;
    } flush_flags_t;

    typedef struct packed {
        logic if_enable;
        logic if_valid;
        logic id_enable;
        logic id_valid;
        logic exe_enable;
        logic exe_valid;
        logic mem_enable;
        logic mem_valid;
        logic wb_valid;           // Also permits the MEM access.
    } stage_ctrl_t;

endpackage

`default_nettype wire

// File: src/rv_ops_pkg.sv
`default_nettype none

`include "hazard_defines.svh"

package rv_ops_pkg;

    // Decode stage class.
    typedef enum logic [`CD_CTRL_W-1:0] {
        CD_NONE    = 3'd0,
        CD_BRANCH  = 3'd1,
        CD_JALR    = 3'd2,
        CD_JAL     = 3'd3,
        CD_FENCE_I = 3'd4,
        CD_SYSTEM  = 3'd5,
        CD_OTHER   = 3'd6
    } cd_ctrl_e;

    typedef enum logic [`IFREG_SEL_W-1:0] {
        IFREG_SEQ   = 1'b0,  // Sequential fetch.
        IFREG_ID_PC = 1'b1   // Target computed in ID.
    } ifreg_sel_e;

    typedef enum logic [`WB_REDIRECT_W-1:0] {
        WBR_NONE  = 2'd0,
        WBR_MTVEC = 2'd1,    // Trap entry.
        WBR_MEPC  = 2'd2     // Return from trap.
    } wb_redirect_e;

    // Only NOP is looked at by the hazard logic.
    typedef enum logic [`EXE_OP_W-1:0] {
        EXE_NOP  = 5'd0,
        EXE_ADD  = 5'd1,
        EXE_SUB  = 5'd2,
        EXE_AND  = 5'd3,
        EXE_OR   = 5'd4,
        EXE_XOR  = 5'd5,
        EXE_SLL  = 5'd6,
        EXE_SRL  = 5'd7,
        EXE_SRA  = 5'd8,
        EXE_SLT  = 5'd9,
        EXE_SLTU = 5'd10,
        EXE_MUL  = 5'd11,
        EXE_DIV  = 5'd12,
        EXE_REM  = 5'd13
    } exe_op_e;

    typedef enum logic [`EXE_SRC_W-1:0] {
        SRC_NONE        = 3'd0,
        SRC_R_R         = 3'd1,
        SRC_R_I         = 3'd2,
        SRC_PC_I        = 3'd3,
        SRC_R_CSR       = 3'd4,
        SRC_NOTR_CSR    = 3'd5,
        SRC_CSR_ZIMM    = 3'd6,
        SRC_CSR_NOTZIMM = 3'd7
    } exe_src_e;

    typedef enum logic [`MEM_OP_W-1:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LD   = 4'd4,
        MEM_LBU  = 4'd5,
        MEM_LHU  = 4'd6,
        MEM_LWU  = 4'd7,
        MEM_SB   = 4'd8,
        MEM_SH   = 4'd9,
        MEM_SW   = 4'd10,
        MEM_SD   = 4'd11
    } mem_op_e;

    typedef enum logic [`WB_SEL_W-1:0] {
        WB_NONE   = 3'd0,
        WB_EXE    = 3'd1,
        WB_MEM    = 3'd2,
        WB_IMM    = 3'd3,
        WB_SNPC   = 3'd4,
        WB_CSRRW  = 3'd5,
        WB_CSRRS  = 3'd6,
        WB_CSRRWI = 3'd7
    } wb_sel_e;

    typedef enum logic [`TRAP_W-1:0] {
        TRAP_NOP         = 4'd0,
        TRAP_IADDR_MIS   = 4'd1,
        TRAP_ILLEGAL     = 4'd2,
        TRAP_EBREAK      = 4'd3,
        TRAP_LADDR_MIS   = 4'd4,
        TRAP_SADDR_MIS   = 4'd5,
        TRAP_ECALL       = 4'd6,
        TRAP_MRET        = 4'd7,
        TRAP_INTERRUPT   = 4'd8
    } trap_e;

endpackage

`default_nettype wire

// File: src/hazard_defines.svh
`ifndef HAZARD_DEFINES_SVH
`define HAZARD_DEFINES_SVH

// Architectural field widths.
`define REG_ADDR_W      5
`define CSR_ADDR_W      12
`define TRAP_W          4

// Control code widths carried by each stage.
`define CD_CTRL_W       3
`define IFREG_SEL_W     1
`define WB_REDIRECT_W   2
`define EXE_OP_W        5
`define EXE_SRC_W       3
`define MEM_OP_W        4
`define WB_SEL_W        3

`endif
